/* compile.f */
verilog/regfile_pkg.sv
verilog/regfile_req_if.sv
verilog/block_ram.sv
verilog/bank_decode.sv
verilog/multipump_sequencer.sv
verilog/read_collector.sv
verilog/multipump_regfile.sv
dv/regfile_checker.sv
dv/regfile_asserts.sv
dv/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the register file testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_top -f compile.f
status=$?
if [ $status -ne 0 ]; then
        echo "build failed with status $status"
        exit 1
fi

output=$(./obj_dir/Vtb_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
        exit 0
fi
exit 1

/* dv/tb_top.sv */
// drives a fixed table of requests, expected words worked out from the bank map.
// registers start at zero, so every expected word follows from earlier table writes.
`timescale 1ns/10ps

module tb_top import regfile_pkg::*; ();

        localparam int NUM_TESTS  = 12;
        localparam int RST_CYCLES = 10;
        localparam int MARGIN     = 40;

        typedef struct packed {
                logic [95:0] name;
                cpu_mode_t   mode;
                arch_reg_t   rd0;
                arch_reg_t   rd1;
                arch_reg_t   rd2;
                logic        we0;
                logic        we1;
                arch_reg_t   wi0;
                arch_reg_t   wi1;
                word_t       wd0;
                word_t       wd1;
                word_t       e0;
                word_t       e1;
                word_t       e2;
        } test_t;

        logic        i_clk_multipump;
        logic        i_rst_n;
        logic        i_valid;
        cpu_mode_t   i_mode;
        arch_reg_t   i_rd_idx0, i_rd_idx1, i_rd_idx2;
        logic        i_wr_en0, i_wr_en1;
        arch_reg_t   i_wr_idx0, i_wr_idx1;
        word_t       i_wr_data0, i_wr_data1;
        logic        o_ready, o_valid;
        word_t       o_rd_data0, o_rd_data1, o_rd_data2;
        logic [95:0] exp_name;
        word_t       exp_data0, exp_data1, exp_data2;
        logic        done;
        int          chk_errors;
        int          tb_errors;
        test_t       tests [NUM_TESTS];

        function automatic test_t make_test(input logic [95:0] name, input cpu_mode_t mode,
                        input arch_reg_t rd0, input arch_reg_t rd1, input arch_reg_t rd2,
                        input logic we0, input arch_reg_t wi0, input word_t wd0,
                        input logic we1, input arch_reg_t wi1, input word_t wd1,
                        input word_t e0, input word_t e1, input word_t e2);
                test_t t;
                t = '{name, mode, rd0, rd1, rd2, we0, we1, wi0, wi1, wd0, wd1, e0, e1, e2};
                return t;
        endfunction

        multipump_regfile i_dut (.*);

        regfile_checker u_checker (
                .i_clk_multipump (i_clk_multipump),
                .i_rst_n (i_rst_n),
                .i_valid (i_valid),
                .i_ready (o_ready),
                .i_res_valid (o_valid),
                .i_rd_data0 (o_rd_data0),
                .i_rd_data1 (o_rd_data1),
                .i_rd_data2 (o_rd_data2),
                .i_exp_name (exp_name),
                .i_exp_data0 (exp_data0),
                .i_exp_data1 (exp_data1),
                .i_exp_data2 (exp_data2),
                .i_done (done),
                .o_errors (chk_errors)
        );

        initial
        begin
                i_clk_multipump = 1'b0;
                forever #5 i_clk_multipump = ~i_clk_multipump;
        end

        // reads before writes, so a request never sees its own writes.
        // disabled write ports carry live rows and data that must not land.
        initial
        begin
                tests[0]  = make_test("reset_rd", MODE_USR, 0, 1, 2, 0, 0, 0, 0, 0, 0, 0, 0, 0);
                tests[1]  = make_test("wr_r3", MODE_USR, 3, 0, 3, 1, 3, 32'h33330001,
                                      0, 0, 0, 0, 0, 0);
                tests[2]  = make_test("rd_r3", MODE_USR, 3, 3, 1, 1, 8, 32'h88880000,
                                      1, 13, 32'hdddd0000, 32'h33330001, 32'h33330001, 0);
                tests[3]  = make_test("fiq_wr", MODE_FIQ, 8, 13, 3, 1, 8, 32'hf8f80008,
                                      1, 13, 32'hfdfd000d, 0, 0, 32'h33330001);
                tests[4]  = make_test("fiq_rd", MODE_FIQ, 8, 13, 0, 0, 0, 0, 0, 0, 0,
                                      32'hf8f80008, 32'hfdfd000d, 0);
                tests[5]  = make_test("usr_rd", MODE_USR, 8, 13, 9, 0, 3, 32'hbad00003,
                                      1, 15, 32'h0000f00c, 32'h88880000, 32'hdddd0000, 0);
                tests[6]  = make_test("svc_same", MODE_SVC, 13, 15, 14, 1, 13, 32'h5c5c0000,
                                      1, 13, 32'h5c5c1111, 0, 32'h0000f00c, 0);
                tests[7]  = make_test("irq_r13", MODE_IRQ, 13, 15, 3, 1, 14, 32'h1e1e0014,
                                      0, 0, 0, 0, 32'h0000f00c, 32'h33330001);
                tests[8]  = make_test("svc_rd", MODE_SVC, 13, 14, 13, 0, 0, 0,
                                      0, 15, 32'hbad0000f, 32'h5c5c1111, 0, 32'h5c5c1111);
                tests[9]  = make_test("sys_rd", MODE_SYS, 13, 8, 15, 1, 0, 32'ha0a00000,
                                      1, 7, 32'ha7a70007, 32'hdddd0000, 32'h88880000,
                                      32'h0000f00c);
                tests[10] = make_test("abt_rd", MODE_ABT, 0, 7, 13, 1, 14, 32'habab000e,
                                      0, 0, 0, 32'ha0a00000, 32'ha7a70007, 0);
                tests[11] = make_test("und_rd", MODE_UND, 14, 0, 3, 0, 0, 0, 0, 0, 0,
                                      0, 32'ha0a00000, 32'h33330001);
        end

        initial
        begin
                i_rst_n    = 1'b0;
                i_valid    = 1'b0;
                i_mode     = MODE_USR;
                i_rd_idx0  = '0;
                i_rd_idx1  = '0;
                i_rd_idx2  = '0;
                i_wr_en0   = 1'b0;
                i_wr_en1   = 1'b0;
                i_wr_idx0  = '0;
                i_wr_idx1  = '0;
                i_wr_data0 = '0;
                i_wr_data1 = '0;
                exp_name   = '0;
                exp_data0  = '0;
                exp_data1  = '0;
                exp_data2  = '0;
                done       = 1'b0;
                tb_errors  = 0;
                repeat (RST_CYCLES) @(posedge i_clk_multipump);
                i_rst_n <= 1'b1;
                @(negedge i_clk_multipump);
                if (o_ready !== 1'b1 || o_valid !== 1'b0)
                begin
                        $display("error reset ready/valid expected 10 actual %b%b", o_ready, o_valid);
                        tb_errors++;
                end
                for (int i = 0; i < NUM_TESTS; i++)
                begin
                        @(negedge i_clk_multipump);
                        while (o_ready !== 1'b1)
                                @(negedge i_clk_multipump);
                        @(posedge i_clk_multipump);
                        i_valid    <= 1'b1;
                        i_mode     <= tests[i].mode;
                        i_rd_idx0  <= tests[i].rd0;
                        i_rd_idx1  <= tests[i].rd1;
                        i_rd_idx2  <= tests[i].rd2;
                        i_wr_en0   <= tests[i].we0;
                        i_wr_en1   <= tests[i].we1;
                        i_wr_idx0  <= tests[i].wi0;
                        i_wr_idx1  <= tests[i].wi1;
                        i_wr_data0 <= tests[i].wd0;
                        i_wr_data1 <= tests[i].wd1;
                        exp_name   <= tests[i].name;
                        exp_data0  <= tests[i].e0;
                        exp_data1  <= tests[i].e1;
                        exp_data2  <= tests[i].e2;
                        @(posedge i_clk_multipump);
                        i_valid <= 1'b0;        // one-cycle request.
                end
                repeat (RESULT_LATENCY + 2) @(posedge i_clk_multipump);
                done <= 1'b1;
                repeat (2) @(posedge i_clk_multipump);
                $display("errors: %0d checker, %0d testbench", chk_errors, tb_errors);
                if (chk_errors == 0 && tb_errors == 0)
                        $display("Simulation passed");
                else
                        $display("Simulation failed");
                $finish;
        end

        // each request needs at most 8 cycles including the ready wait.
        initial
        begin
                #((RST_CYCLES + NUM_TESTS * 8 + MARGIN) * 10);
                $display("timeout: the run did not finish within the time limit");
                $display("errors: %0d checker, %0d testbench", chk_errors, tb_errors + 1);
                $display("Simulation failed");
                $finish;
        end

endmodule

/* dv/regfile_asserts.sv */
// handshake and latency rules of the register file top level.
`timescale 1ns/10ps

module regfile_asserts import regfile_pkg::*; (
        input logic i_clk_multipump,
        input logic i_rst_n,
        input logic i_valid,
        input logic o_ready,
        input logic o_valid
);

        // host only issues while ready.
        a_valid_when_ready: assert property (@(posedge i_clk_multipump) disable iff (!i_rst_n)
                i_valid |-> o_ready)
                else $error("i_valid asserted while o_ready low");

        // o_valid rises RESULT_LATENCY edges after acceptance and samples high one edge later.
        a_result_latency: assert property (@(posedge i_clk_multipump) disable iff (!i_rst_n)
                i_valid |=> ##RESULT_LATENCY o_valid)
                else $error("o_valid missing after accepted request");

        a_valid_pulse: assert property (@(posedge i_clk_multipump) disable iff (!i_rst_n)
                o_valid |=> !o_valid)
                else $error("o_valid high for more than one cycle");

endmodule

bind multipump_regfile regfile_asserts u_asserts (
        .i_clk_multipump (i_clk_multipump),
        .i_rst_n         (i_rst_n),
        .i_valid         (i_valid),
        .o_ready         (o_ready),
        .o_valid         (o_valid)
);

/* dv/regfile_checker.sv */
// compares each o_valid result with the words captured when i_valid was accepted.
// expects one request in flight, latency fixed at RESULT_LATENCY cycles.
`timescale 1ns/10ps

module regfile_checker import regfile_pkg::*; (
        input  logic         i_clk_multipump,
        input  logic         i_rst_n,
        input  logic         i_valid,            // DUT input, marks an accepted request.
        input  logic         i_ready,            // DUT o_ready.
        input  logic         i_res_valid,        // DUT o_valid.
        input  word_t        i_rd_data0,
        input  word_t        i_rd_data1,
        input  word_t        i_rd_data2,
        input  logic [95:0]  i_exp_name,         // test name, ascii.
        input  word_t        i_exp_data0,
        input  word_t        i_exp_data1,
        input  word_t        i_exp_data2,
        input  logic         i_done,             // no more requests follow.
        output int           o_errors
);

        logic        pending;
        int          cycles;                     // edges since the accepting edge.
        logic [95:0] cur_name;
        word_t       cur_exp0;
        word_t       cur_exp1;
        word_t       cur_exp2;

        task automatic compare_word(input string label, input word_t exp, input word_t act);
                if (exp !== act)
                begin
                        $display("error %0s %0s expected %h actual %h", cur_name, label, exp, act);
                        o_errors++;
                end
        endtask

        initial
        begin
                o_errors = 0;
                pending  = 1'b0;
                cycles   = 0;
        end

        // outputs are sampled before the edge updates them.
        always @(posedge i_clk_multipump)
        begin
                if (i_rst_n)
                begin
                        if (i_res_valid)
                        begin
                                if (!pending)
                                begin
                                        $display("result pulse arrived with no request outstanding");
                                        o_errors++;
                                end
                                else
                                begin
                                        if (cycles != RESULT_LATENCY)
                                        begin
                                                $display("error %0s latency expected %0d actual %0d",
                                                         cur_name, RESULT_LATENCY, cycles);
                                                o_errors++;
                                        end
                                        compare_word("rd0", cur_exp0, i_rd_data0);
                                        compare_word("rd1", cur_exp1, i_rd_data1);
                                        compare_word("rd2", cur_exp2, i_rd_data2);
                                        pending = 1'b0;
                                end
                        end
                        else if (pending && i_ready)
                        begin
                                $display("ready went high while request %0s was in flight", cur_name);
                                o_errors++;
                        end

                        if (pending)
                        begin
                                cycles++;
                                if (cycles > RESULT_LATENCY + 3)
                                begin
                                        $display("no result returned for request %0s", cur_name);
                                        o_errors++;
                                        pending = 1'b0;
                                end
                        end

                        if (i_valid)
                        begin
                                if (pending)
                                begin
                                        $display("new request issued before %0s returned", cur_name);
                                        o_errors++;
                                end
                                pending  = 1'b1;
                                cycles   = 0;    // counted from the accepting edge.
                                cur_name = i_exp_name;
                                cur_exp0 = i_exp_data0;
                                cur_exp1 = i_exp_data1;
                                cur_exp2 = i_exp_data2;
                        end

                        if (i_done && pending)
                        begin
                                $display("no result returned for last request %0s", cur_name);
                                o_errors++;
                                pending = 1'b0;
                        end
                end
        end

endmodule

/* verilog/multipump_regfile.sv */
// banked ARM register file, reads see state before this request's writes.
// i_valid only when o_ready, o_valid is a pulse with no back-pressure.
`timescale 1ns/10ps

module multipump_regfile import regfile_pkg::*; (
        input  logic      i_clk_multipump,
        input  logic      i_rst_n,
        input  logic      i_valid,
        input  cpu_mode_t i_mode,
        input  arch_reg_t i_rd_idx0,
        input  arch_reg_t i_rd_idx1,
        input  arch_reg_t i_rd_idx2,
        input  logic      i_wr_en0,
        input  logic      i_wr_en1,
        input  arch_reg_t i_wr_idx0,
        input  arch_reg_t i_wr_idx1,
        input  word_t     i_wr_data0,
        input  word_t     i_wr_data1,
        output logic      o_ready,
        output logic      o_valid,
        output word_t     o_rd_data0,
        output word_t     o_rd_data1,
        output word_t     o_rd_data2
);

        logic       busy;
        logic       capture;
        logic [1:0] slot;
        word_t      rd_word;

        regfile_req_if req_if ();

        bank_decode u_decode (
                .i_clk_multipump (i_clk_multipump),
                .i_rst_n         (i_rst_n),
                .i_valid         (i_valid),
                .i_mode          (i_mode),
                .i_rd_idx0       (i_rd_idx0),
                .i_rd_idx1       (i_rd_idx1),
                .i_rd_idx2       (i_rd_idx2),
                .i_wr_idx0       (i_wr_idx0),
                .i_wr_idx1       (i_wr_idx1),
                .i_wr_en0        (i_wr_en0),
                .i_wr_en1        (i_wr_en1),
                .i_wr_data0      (i_wr_data0),
                .i_wr_data1      (i_wr_data1),
                .o_req           (req_if.decode)
        );

        multipump_sequencer u_execute (
                .i_clk_multipump (i_clk_multipump),
                .i_rst_n         (i_rst_n),
                .i_req           (req_if.sequencer),
                .o_busy          (busy),
                .o_capture       (capture),
                .o_slot          (slot),
                .o_rd_word       (rd_word)
        );

        read_collector u_result (
                .i_clk_multipump (i_clk_multipump),
                .i_rst_n         (i_rst_n),
                .i_capture       (capture),
                .i_slot          (slot),
                .i_rd_word       (rd_word),
                .o_valid         (o_valid),
                .o_rd_data0      (o_rd_data0),
                .o_rd_data1      (o_rd_data1),
                .o_rd_data2      (o_rd_data2)
        );

        assign o_ready = ~busy;         // low from the accepting edge until o_valid rises.

endmodule

/* verilog/read_collector.sv */
// collects the three read words, results stay put until the next request overwrites them.
`timescale 1ns/10ps

module read_collector import regfile_pkg::*; (
        input  logic       i_clk_multipump,
        input  logic       i_rst_n,
        input  logic       i_capture,
        input  logic [1:0] i_slot,
        input  word_t      i_rd_word,
        output logic       o_valid,
        output word_t      o_rd_data0,
        output word_t      o_rd_data1,
        output word_t      o_rd_data2
);

        logic last_slot;

        assign last_slot = i_capture && (i_slot == 2'd2);

        always_ff @(posedge i_clk_multipump or negedge i_rst_n)
        begin
                if (!i_rst_n)
                        o_valid <= 1'b0;
                else
                        o_valid <= last_slot;   // one pulse, all three words in place.
        end

        always_ff @(posedge i_clk_multipump)
        begin
                if (i_capture)
                begin
                        case (i_slot)
                                2'd0:    o_rd_data0 <= i_rd_word;
                                2'd1:    o_rd_data1 <= i_rd_word;
                                2'd2:    o_rd_data2 <= i_rd_word;
                                default: o_rd_data0 <= o_rd_data0;  // slot 3 unused.
                        endcase
                end
        end

endmodule

/* verilog/multipump_sequencer.sv */
// pumps the RAM through three read phases and one write phase per request.
// one request in flight, a new req_valid during a busy phase is ignored.
`timescale 1ns/10ps

module multipump_sequencer import regfile_pkg::*; (
        input  logic       i_clk_multipump,
        input  logic       i_rst_n,
        regfile_req_if.sequencer i_req,
        output logic       o_busy,
        output logic       o_capture,       // RAM output holds a read word.
        output logic [1:0] o_slot,          // which read it is.
        output word_t      o_rd_word
);

        phase_t    phase;
        phase_t    phase_nxt;
        phys_reg_t addr_a;
        phys_reg_t addr_b;
        word_t     data_a;
        word_t     data_b;
        logic      wen;

        always_comb
        begin
                phase_nxt = phase;
                case (phase)
                        PH_IDLE:  if (i_req.req_valid) phase_nxt = PH_READ0;
                        PH_READ0: phase_nxt = PH_READ1;
                        PH_READ1: phase_nxt = PH_READ2;
                        PH_READ2: phase_nxt = PH_WRITE;
                        PH_WRITE: phase_nxt = PH_IDLE;
                        default:  phase_nxt = PH_IDLE;
                endcase
        end

        always_ff @(posedge i_clk_multipump or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        phase     <= PH_IDLE;
                        o_capture <= 1'b0;
                        o_slot    <= 2'd0;
                end
                else
                begin
                        phase     <= phase_nxt;
                        // one cycle behind the read phase, same as RAM latency.
                        o_capture <= (phase == PH_READ0) || (phase == PH_READ1) ||
                                     (phase == PH_READ2);
                        case (phase)
                                PH_READ1: o_slot <= 2'd1;
                                PH_READ2: o_slot <= 2'd2;
                                default:  o_slot <= 2'd0;
                        endcase
                end
        end

        // a single write drives both ports with the same row and data.
        assign addr_b = i_req.wr_en1 ? i_req.wr_row1  : i_req.wr_row0;
        assign data_a = i_req.wr_en0 ? i_req.wr_data0 : i_req.wr_data1;
        assign data_b = i_req.wr_en1 ? i_req.wr_data1 : i_req.wr_data0;
        assign wen    = (phase == PH_WRITE) && (i_req.wr_en0 || i_req.wr_en1);

        always_comb
        begin
                case (phase)
                        PH_READ0: addr_a = i_req.rd_row0;
                        PH_READ1: addr_a = i_req.rd_row1;
                        PH_READ2: addr_a = i_req.rd_row2;
                        PH_WRITE: addr_a = i_req.wr_en0 ? i_req.wr_row0 : i_req.wr_row1;
                        default:  addr_a = i_req.rd_row0;       // read result unused.
                endcase
        end

        assign o_busy = i_req.req_valid || (phase != PH_IDLE);

        block_ram u_ram (
                .i_clk_multipump (i_clk_multipump),
                .i_addr_a        (addr_a),
                .i_addr_b        (addr_b),
                .i_wen           (wen),
                .i_wr_data_a     (data_a),
                .i_wr_data_b     (data_b),
                .o_rd_data_a     (o_rd_word)
        );

endmodule

/* verilog/bank_decode.sv */
// banks the five register numbers by mode and registers one request per i_valid.
// host must only pulse i_valid while the register file is ready.
`timescale 1ns/10ps

module bank_decode import regfile_pkg::*; (
        input  logic      i_clk_multipump,
        input  logic      i_rst_n,
        input  logic      i_valid,
        input  cpu_mode_t i_mode,
        input  arch_reg_t i_rd_idx0,
        input  arch_reg_t i_rd_idx1,
        input  arch_reg_t i_rd_idx2,
        input  arch_reg_t i_wr_idx0,
        input  arch_reg_t i_wr_idx1,
        input  logic      i_wr_en0,
        input  logic      i_wr_en1,
        input  word_t     i_wr_data0,
        input  word_t     i_wr_data1,
        regfile_req_if.decode o_req
);

        // r13/r14 banked modes share one rule, only the base row differs.
        function automatic phys_reg_t map_row(input cpu_mode_t mode, input arch_reg_t idx);
                phys_reg_t row;
                phys_reg_t base;
                logic      hi_bank;
                row     = phys_reg_t'(idx);     // user, system and unknown modes.
                base    = ROW_IRQ;
                hi_bank = 1'b0;
                case (mode)
                        MODE_FIQ:
                        begin
                                if (idx >= 4'd8 && idx <= 4'd14)
                                        row = ROW_FIQ + phys_reg_t'(idx - 4'd8);
                        end
                        MODE_IRQ: begin hi_bank = 1'b1; base = ROW_IRQ; end
                        MODE_SVC: begin hi_bank = 1'b1; base = ROW_SVC; end
                        MODE_ABT: begin hi_bank = 1'b1; base = ROW_ABT; end
                        MODE_UND: begin hi_bank = 1'b1; base = ROW_UND; end
                        default:  hi_bank = 1'b0;
                endcase
                if (hi_bank && (idx == 4'd13 || idx == 4'd14))
                        row = base + phys_reg_t'(idx - 4'd13);
                return row;
        endfunction

        always_ff @(posedge i_clk_multipump or negedge i_rst_n)
        begin
                if (!i_rst_n)
                        o_req.req_valid <= 1'b0;
                else
                        o_req.req_valid <= i_valid;     // pulse, host drops i_valid next edge.
        end

        // payload held until the next accepted request.
        always_ff @(posedge i_clk_multipump)
        begin
                if (i_valid)
                begin
                        o_req.rd_row0  <= map_row(i_mode, i_rd_idx0);
                        o_req.rd_row1  <= map_row(i_mode, i_rd_idx1);
                        o_req.rd_row2  <= map_row(i_mode, i_rd_idx2);
                        o_req.wr_row0  <= map_row(i_mode, i_wr_idx0);
                        o_req.wr_row1  <= map_row(i_mode, i_wr_idx1);
                        o_req.wr_en0   <= i_wr_en0;
                        o_req.wr_en1   <= i_wr_en1;
                        o_req.wr_data0 <= i_wr_data0;
                        o_req.wr_data1 <= i_wr_data1;
                end
        end

endmodule

/* verilog/block_ram.sv */
// two write ports on one enable, one registered read port with read-old behavior.
// contents start at zero in simulation only.
`timescale 1ns/10ps

module block_ram import regfile_pkg::*; #(
        parameter int DATA_WDT = regfile_pkg::DATA_WDT,
        parameter int ADDR_WDT = regfile_pkg::ADDR_WDT,
        parameter int DEPTH    = regfile_pkg::DEPTH
)
(
        input  logic                i_clk_multipump,
        input  logic [ADDR_WDT-1:0] i_addr_a,       // read and write address.
        input  logic [ADDR_WDT-1:0] i_addr_b,       // write only.
        input  logic                i_wen,
        input  logic [DATA_WDT-1:0] i_wr_data_a,
        input  logic [DATA_WDT-1:0] i_wr_data_b,
        output logic [DATA_WDT-1:0] o_rd_data_a
);

        logic [DATA_WDT-1:0] mem [DEPTH];

        initial
        begin
                for (int i = 0; i < DEPTH; i++)
                begin
                        mem[i] = '0;
                end
        end

        // port b is written last, so it wins on equal addresses.
        always @(posedge i_clk_multipump)
        begin
                if (i_wen)
                begin
                        mem[i_addr_a] <= i_wr_data_a;
                        mem[i_addr_b] <= i_wr_data_b;
                end
        end

        always_ff @(posedge i_clk_multipump)
        begin
                o_rd_data_a <= mem[i_addr_a];   // old word on a same-edge write.
        end

endmodule

/* verilog/regfile_req_if.sv */
// one decoded request, rows and data held stable until the next req_valid pulse.
`timescale 1ns/10ps

interface regfile_req_if import regfile_pkg::*; ();

        logic      req_valid;   // one cycle pulse.
        phys_reg_t rd_row0;
        phys_reg_t rd_row1;
        phys_reg_t rd_row2;
        logic      wr_en0;
        logic      wr_en1;
        phys_reg_t wr_row0;
        phys_reg_t wr_row1;
        word_t     wr_data0;
        word_t     wr_data1;

        modport decode (
                output req_valid,
                output rd_row0, rd_row1, rd_row2,
                output wr_en0, wr_en1,
                output wr_row0, wr_row1,
                output wr_data0, wr_data1
        );

        modport sequencer (
                input req_valid,
                input rd_row0, rd_row1, rd_row2,
                input wr_en0, wr_en1,
                input wr_row0, wr_row1,
                input wr_data0, wr_data1
        );

endinterface

/* verilog/regfile_pkg.sv */
// shared widths, ARM mode codes and bank row map for the register file.
// modes outside the list below decode as user.
package regfile_pkg;

        typedef logic [31:0] word_t;            // one register value.
        typedef logic [3:0]  arch_reg_t;        // r0..r15 as seen by software.
        typedef logic [5:0]  phys_reg_t;        // row in the block RAM.
        typedef logic [4:0]  cpu_mode_t;        // CPSR mode field.

        // ARM mode encodings.
        localparam cpu_mode_t MODE_USR = 5'b10000;
        localparam cpu_mode_t MODE_FIQ = 5'b10001;
        localparam cpu_mode_t MODE_IRQ = 5'b10010;
        localparam cpu_mode_t MODE_SVC = 5'b10011;
        localparam cpu_mode_t MODE_ABT = 5'b10111;
        localparam cpu_mode_t MODE_UND = 5'b11011;
        localparam cpu_mode_t MODE_SYS = 5'b11111;

        // first row of each banked group, rows 0..15 are user/system.
        localparam phys_reg_t ROW_FIQ = 6'd16;  // r8..r14.
        localparam phys_reg_t ROW_IRQ = 6'd23;  // r13..r14.
        localparam phys_reg_t ROW_SVC = 6'd25;
        localparam phys_reg_t ROW_ABT = 6'd27;
        localparam phys_reg_t ROW_UND = 6'd29;

        // block RAM defaults.
        localparam int DATA_WDT = 32;
        localparam int ADDR_WDT = 6;
        localparam int DEPTH    = 64;

        localparam int RESULT_LATENCY = 5;      // i_valid edge to o_valid edge.

        typedef enum logic [2:0] {
                PH_IDLE,
                PH_READ0,
                PH_READ1,
                PH_READ2,
                PH_WRITE
        } phase_t;

endpackage
